/* hw/vproc_mem_pkg.sv */
// vector coprocessor memory fabric
// shared widths, response queue depth and the 64-bit bus word

package vproc_mem_pkg;

    ////////////////////////////////////////////////////////////
    // widths

    localparam int unsigned ADDR_W   = 32;
    localparam int unsigned WORD_W   = 32;          // scalar and fetch word
    localparam int unsigned MEM_W    = 64;          // bus and vector data
    localparam int unsigned MEM_BE_W = MEM_W / 8;

    // 32-bit lanes in one bus word
    localparam int unsigned LANE_CNT     = MEM_W / WORD_W;
    localparam int unsigned LANE_SEL_BIT = 2;       // address bit picking the lane

    ////////////////////////////////////////////////////////////
    // response ordering

    // the external memory keeps at most RESP_DEPTH - 1 requests in flight
    localparam int unsigned RESP_DEPTH = 32;
    localparam int unsigned RESP_CNT_W = 5;

    ////////////////////////////////////////////////////////////
    // bus word

    // vector accesses use the raw word,
    // scalar and fetch accesses pick one of the lanes
    typedef union packed {
        logic [MEM_W-1:0]                raw;
        logic [LANE_CNT-1:0][WORD_W-1:0] lanes;   // lane 0 in the low half
    } mem_word_u;

endpackage

/* hw/ls_data_arbiter.sv */
// load/store data arbiter
// merges the scalar and vector load/store ports onto one 64-bit data port

module ls_data_arbiter (
    input  logic                                 clk_i,
    input  logic                                 rst_ni,

    // scalar load/store port
    input  logic                                 sdata_req_i,
    input  logic [vproc_mem_pkg::WORD_W-1:0]     sdata_addr_i,
    input  logic                                 sdata_we_i,
    input  logic [vproc_mem_pkg::WORD_W/8-1:0]   sdata_be_i,
    input  logic [vproc_mem_pkg::WORD_W-1:0]     sdata_wdata_i,
    output logic                                 sdata_gnt_o,
    output logic                                 sdata_rvalid_o,
    output logic                                 sdata_err_o,
    output logic [vproc_mem_pkg::WORD_W-1:0]     sdata_rdata_o,

    // vector load/store port
    input  logic                                 vdata_req_i,
    input  logic [vproc_mem_pkg::ADDR_W-1:0]     vdata_addr_i,
    input  logic                                 vdata_we_i,
    input  logic [vproc_mem_pkg::MEM_BE_W-1:0]   vdata_be_i,
    input  vproc_mem_pkg::mem_word_u             vdata_wdata_i,
    output logic                                 vdata_gnt_o,
    output logic                                 vdata_rvalid_o,
    output logic                                 vdata_err_o,
    output vproc_mem_pkg::mem_word_u             vdata_rdata_o,

    input  logic                                 pending_load_i,
    input  logic                                 pending_store_i,

    // merged data port
    output logic                                 data_req_o,
    output logic [vproc_mem_pkg::ADDR_W-1:0]     data_addr_o,
    output logic                                 data_we_o,
    output logic [vproc_mem_pkg::MEM_BE_W-1:0]   data_be_o,
    output vproc_mem_pkg::mem_word_u             data_wdata_o,
    input  logic                                 data_gnt_i,
    input  logic                                 data_rvalid_i,
    input  logic                                 data_err_i,
    input  vproc_mem_pkg::mem_word_u             data_rdata_i
);

    logic sdata_hold;
    logic sdata_waiting_q, vdata_waiting_q;
    logic sdata_wait_lane_q;   // lane of the outstanding scalar access

    // scalar accesses must not overtake vector loads and stores
    assign sdata_hold = vdata_req_i | pending_store_i | (pending_load_i & sdata_we_i);

    ////////////////////////////////////////////////////////////
    // request path

    always_comb begin
        data_req_o = vdata_req_i | (sdata_req_i & ~sdata_hold);
        if (vdata_req_i) begin
            data_addr_o  = vdata_addr_i;
            data_we_o    = vdata_we_i;
            data_be_o    = vdata_be_i;
            data_wdata_o = vdata_wdata_i;
        end else begin
            data_addr_o = sdata_addr_i;
            data_we_o   = sdata_we_i;
            // move byte enables into the addressed lane
            if (sdata_addr_i[vproc_mem_pkg::LANE_SEL_BIT]) begin
                data_be_o = {sdata_be_i, 4'b0000};
            end else begin
                data_be_o = {4'b0000, sdata_be_i};
            end
            data_wdata_o.lanes[0] = sdata_wdata_i;   // same word in both lanes
            data_wdata_o.lanes[1] = sdata_wdata_i;
        end
    end

    assign sdata_gnt_o = data_gnt_i & sdata_req_i & ~sdata_hold;
    assign vdata_gnt_o = data_gnt_i & vdata_req_i;

    ////////////////////////////////////////////////////////////
    // response path

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (~rst_ni) begin
            sdata_waiting_q   <= 1'b0;
            vdata_waiting_q   <= 1'b0;
            sdata_wait_lane_q <= 1'b0;
        end else begin
            if (sdata_gnt_o) begin
                sdata_waiting_q   <= 1'b1;
                sdata_wait_lane_q <= sdata_addr_i[vproc_mem_pkg::LANE_SEL_BIT];
            end else if (sdata_rvalid_o) begin
                sdata_waiting_q <= 1'b0;
            end
            if (vdata_gnt_o) begin
                vdata_waiting_q <= 1'b1;
            end else if (vdata_rvalid_o) begin
                vdata_waiting_q <= 1'b0;
            end
        end
    end

    assign sdata_rvalid_o = sdata_waiting_q & data_rvalid_i;
    assign vdata_rvalid_o = vdata_waiting_q & data_rvalid_i;
    assign sdata_err_o    = data_err_i;
    assign vdata_err_o    = data_err_i;
    assign sdata_rdata_o  = data_rdata_i.lanes[sdata_wait_lane_q];
    assign vdata_rdata_o  = data_rdata_i;

endmodule

/* hw/resp_order_queue.sv */
// in-order response queue
// records source, write flag and fetch address of each granted bus request

module resp_order_queue (
    input  logic                              clk_i,
    input  logic                              rst_ni,

    input  logic                              push_i,
    input  logic                              push_src_data_i,   // 1 for data, 0 for fetch
    input  logic                              push_write_i,
    input  logic [vproc_mem_pkg::ADDR_W-1:0]  push_addr_i,
    input  logic                              pop_i,

    output logic                              head_src_data_o,
    output logic                              head_write_o,
    output logic [vproc_mem_pkg::ADDR_W-1:0]  head_addr_o
);

    logic                             src_data_q [vproc_mem_pkg::RESP_DEPTH];
    logic                             write_q    [vproc_mem_pkg::RESP_DEPTH];
    logic [vproc_mem_pkg::ADDR_W-1:0] addr_q     [vproc_mem_pkg::RESP_DEPTH];

    logic [vproc_mem_pkg::RESP_CNT_W-1:0] count_q;
    logic [vproc_mem_pkg::RESP_CNT_W-1:0] wr_idx;

    // entries move down on a pop, so the free slot is one lower
    assign wr_idx = pop_i ? count_q - 1'b1 : count_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (~rst_ni) begin
            count_q <= '0;
        end else if (push_i & ~pop_i) begin
            count_q <= count_q + 1'b1;
        end else if (pop_i & ~push_i) begin
            count_q <= count_q - 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // entry storage

    always_ff @(posedge clk_i) begin
        if (pop_i) begin
            for (int i = 0; i < vproc_mem_pkg::RESP_DEPTH - 1; i++) begin
                src_data_q[i] <= src_data_q[i+1];
                write_q[i]    <= write_q[i+1];
                addr_q[i]     <= addr_q[i+1];
            end
        end
        if (push_i) begin
            src_data_q[wr_idx] <= push_src_data_i;
            write_q[wr_idx]    <= push_write_i;
            addr_q[wr_idx]     <= push_addr_i;
        end
    end

    assign head_src_data_o = src_data_q[0];
    assign head_write_o    = write_q[0];
    assign head_addr_o     = addr_q[0];

endmodule

/* hw/mem_port_arbiter.sv */
// memory port arbiter
// merges instruction fetch and the data port onto the external bus, data first

module mem_port_arbiter (
    input  logic                                 clk_i,
    input  logic                                 rst_ni,

    // instruction fetch
    input  logic                                 instr_req_i,
    input  logic [vproc_mem_pkg::ADDR_W-1:0]     instr_addr_i,
    output logic                                 instr_gnt_o,
    output logic                                 instr_rvalid_o,
    output logic                                 instr_err_o,
    output logic [vproc_mem_pkg::WORD_W-1:0]     instr_rdata_o,

    // data port
    input  logic                                 data_req_i,
    input  logic [vproc_mem_pkg::ADDR_W-1:0]     data_addr_i,
    input  logic                                 data_we_i,
    input  logic [vproc_mem_pkg::MEM_BE_W-1:0]   data_be_i,
    input  vproc_mem_pkg::mem_word_u             data_wdata_i,
    output logic                                 data_gnt_o,
    output logic                                 data_rvalid_o,
    output logic                                 data_err_o,
    output vproc_mem_pkg::mem_word_u             data_rdata_o,

    // external bus
    output logic                                 mem_req_o,
    output logic [vproc_mem_pkg::ADDR_W-1:0]     mem_addr_o,
    output logic                                 mem_we_o,
    output logic [vproc_mem_pkg::MEM_BE_W-1:0]   mem_be_o,
    output vproc_mem_pkg::mem_word_u             mem_wdata_o,
    input  logic                                 mem_rvalid_i,
    input  logic                                 mem_err_i,
    input  vproc_mem_pkg::mem_word_u             mem_rdata_i
);

    logic                             head_src_data;
    logic                             head_write;
    logic [vproc_mem_pkg::ADDR_W-1:0] head_addr;

    ////////////////////////////////////////////////////////////
    // request side

    assign data_gnt_o  = data_req_i;
    assign instr_gnt_o = instr_req_i & ~data_req_i;

    assign mem_req_o   = instr_req_i | data_req_i;
    assign mem_addr_o  = data_req_i ? data_addr_i : instr_addr_i;
    assign mem_we_o    = data_req_i & data_we_i;       // fetches never write
    assign mem_be_o    = data_req_i ? data_be_i : '1;
    assign mem_wdata_o = data_wdata_i;

    // every bus request is pushed, every response pops
    resp_order_queue i_resp_queue (
        .clk_i           ( clk_i                   ),
        .rst_ni          ( rst_ni                  ),
        .push_i          ( mem_req_o               ),
        .push_src_data_i ( data_req_i              ),
        .push_write_i    ( data_req_i & data_we_i  ),
        .push_addr_i     ( instr_addr_i            ),
        .pop_i           ( mem_rvalid_i            ),
        .head_src_data_o ( head_src_data           ),
        .head_write_o    ( head_write              ),
        .head_addr_o     ( head_addr               )
    );

    ////////////////////////////////////////////////////////////
    // response side

    assign instr_rvalid_o = mem_rvalid_i & ~head_src_data;
    assign data_rvalid_o  = mem_rvalid_i &  head_src_data;  // reads and writes
    assign instr_err_o    = mem_err_i;
    assign data_err_o     = mem_err_i;

    assign instr_rdata_o = mem_rdata_i.lanes[head_addr[vproc_mem_pkg::LANE_SEL_BIT]];
    // write responses carry no data
    assign data_rdata_o  = head_write ? '0 : mem_rdata_i;

endmodule

/* hw/vproc_mem_fabric.sv */
// memory-side fabric of the vector coprocessor system
// scalar and vector load/store plus instruction fetch onto one 64-bit bus

module vproc_mem_fabric (
    input  logic                                 clk_i,
    input  logic                                 rst_ni,

    input  logic                                 instr_req_i,
    input  logic [vproc_mem_pkg::ADDR_W-1:0]     instr_addr_i,
    output logic                                 instr_gnt_o,
    output logic                                 instr_rvalid_o,
    output logic                                 instr_err_o,
    output logic [vproc_mem_pkg::WORD_W-1:0]     instr_rdata_o,

    input  logic                                 sdata_req_i,
    input  logic [vproc_mem_pkg::WORD_W-1:0]     sdata_addr_i,
    input  logic                                 sdata_we_i,
    input  logic [vproc_mem_pkg::WORD_W/8-1:0]   sdata_be_i,
    input  logic [vproc_mem_pkg::WORD_W-1:0]     sdata_wdata_i,
    output logic                                 sdata_gnt_o,
    output logic                                 sdata_rvalid_o,
    output logic                                 sdata_err_o,
    output logic [vproc_mem_pkg::WORD_W-1:0]     sdata_rdata_o,

    input  logic                                 vdata_req_i,
    input  logic [vproc_mem_pkg::ADDR_W-1:0]     vdata_addr_i,
    input  logic                                 vdata_we_i,
    input  logic [vproc_mem_pkg::MEM_BE_W-1:0]   vdata_be_i,
    input  vproc_mem_pkg::mem_word_u             vdata_wdata_i,
    output logic                                 vdata_gnt_o,
    output logic                                 vdata_rvalid_o,
    output logic                                 vdata_err_o,
    output vproc_mem_pkg::mem_word_u             vdata_rdata_o,

    input  logic                                 pending_load_i,
    input  logic                                 pending_store_i,

    output logic                                 mem_req_o,
    output logic [vproc_mem_pkg::ADDR_W-1:0]     mem_addr_o,
    output logic                                 mem_we_o,
    output logic [vproc_mem_pkg::MEM_BE_W-1:0]   mem_be_o,
    output vproc_mem_pkg::mem_word_u             mem_wdata_o,
    input  logic                                 mem_rvalid_i,
    input  logic                                 mem_err_i,
    input  vproc_mem_pkg::mem_word_u             mem_rdata_i
);

    // merged data port between the two arbiters
    logic                               data_req;
    logic [vproc_mem_pkg::ADDR_W-1:0]   data_addr;
    logic                               data_we;
    logic [vproc_mem_pkg::MEM_BE_W-1:0] data_be;
    vproc_mem_pkg::mem_word_u           data_wdata;
    logic                               data_gnt;
    logic                               data_rvalid;
    logic                               data_err;
    vproc_mem_pkg::mem_word_u           data_rdata;

    ls_data_arbiter i_ls_arb (
        .clk_i           ( clk_i           ),
        .rst_ni          ( rst_ni          ),
        .sdata_req_i     ( sdata_req_i     ),
        .sdata_addr_i    ( sdata_addr_i    ),
        .sdata_we_i      ( sdata_we_i      ),
        .sdata_be_i      ( sdata_be_i      ),
        .sdata_wdata_i   ( sdata_wdata_i   ),
        .sdata_gnt_o     ( sdata_gnt_o     ),
        .sdata_rvalid_o  ( sdata_rvalid_o  ),
        .sdata_err_o     ( sdata_err_o     ),
        .sdata_rdata_o   ( sdata_rdata_o   ),
        .vdata_req_i     ( vdata_req_i     ),
        .vdata_addr_i    ( vdata_addr_i    ),
        .vdata_we_i      ( vdata_we_i      ),
        .vdata_be_i      ( vdata_be_i      ),
        .vdata_wdata_i   ( vdata_wdata_i   ),
        .vdata_gnt_o     ( vdata_gnt_o     ),
        .vdata_rvalid_o  ( vdata_rvalid_o  ),
        .vdata_err_o     ( vdata_err_o     ),
        .vdata_rdata_o   ( vdata_rdata_o   ),
        .pending_load_i  ( pending_load_i  ),
        .pending_store_i ( pending_store_i ),
        .data_req_o      ( data_req        ),
        .data_addr_o     ( data_addr       ),
        .data_we_o       ( data_we         ),
        .data_be_o       ( data_be         ),
        .data_wdata_o    ( data_wdata      ),
        .data_gnt_i      ( data_gnt        ),
        .data_rvalid_i   ( data_rvalid     ),
        .data_err_i      ( data_err        ),
        .data_rdata_i    ( data_rdata      )
    );

    mem_port_arbiter i_mem_arb (
        .clk_i          ( clk_i          ),
        .rst_ni         ( rst_ni         ),
        .instr_req_i    ( instr_req_i    ),
        .instr_addr_i   ( instr_addr_i   ),
        .instr_gnt_o    ( instr_gnt_o    ),
        .instr_rvalid_o ( instr_rvalid_o ),
        .instr_err_o    ( instr_err_o    ),
        .instr_rdata_o  ( instr_rdata_o  ),
        .data_req_i     ( data_req       ),
        .data_addr_i    ( data_addr      ),
        .data_we_i      ( data_we        ),
        .data_be_i      ( data_be        ),
        .data_wdata_i   ( data_wdata     ),
        .data_gnt_o     ( data_gnt       ),
        .data_rvalid_o  ( data_rvalid    ),
        .data_err_o     ( data_err       ),
        .data_rdata_o   ( data_rdata     ),
        .mem_req_o      ( mem_req_o      ),
        .mem_addr_o     ( mem_addr_o     ),
        .mem_we_o       ( mem_we_o       ),
        .mem_be_o       ( mem_be_o       ),
        .mem_wdata_o    ( mem_wdata_o    ),
        .mem_rvalid_i   ( mem_rvalid_i   ),
        .mem_err_i      ( mem_err_i      ),
        .mem_rdata_i    ( mem_rdata_i    )
    );

endmodule

/* test/vproc_mem_fabric_assertions.sv */
// protocol checks bound into the memory fabric
// fetch priority, scalar hold and single response per cycle

module fabric_protocol_checks (
    input logic clk_i,
    input logic rst_ni,
    input logic instr_gnt_i,
    input logic sdata_gnt_i,
    input logic vdata_req_i,
    input logic pending_store_i,
    input logic instr_rvalid_i,
    input logic sdata_rvalid_i,
    input logic vdata_rvalid_i
);

    // data always wins the bus
    assert property (@(posedge clk_i) disable iff (!rst_ni)
                     instr_gnt_i |-> !(vdata_req_i || sdata_gnt_i))
        else $error("fetch granted together with a data request");

    assert property (@(posedge clk_i) disable iff (!rst_ni)
                     sdata_gnt_i |-> !(vdata_req_i || pending_store_i))
        else $error("scalar granted during vector activity");

    assert property (@(posedge clk_i) disable iff (!rst_ni)
                     $onehot0({instr_rvalid_i, sdata_rvalid_i, vdata_rvalid_i}))
        else $error("more than one rvalid in a cycle");

endmodule

bind vproc_mem_fabric fabric_protocol_checks i_protocol_checks (
    .clk_i           ( clk_i           ),
    .rst_ni          ( rst_ni          ),
    .instr_gnt_i     ( instr_gnt_o     ),
    .sdata_gnt_i     ( sdata_gnt_o     ),
    .vdata_req_i     ( vdata_req_i     ),
    .pending_store_i ( pending_store_i ),
    .instr_rvalid_i  ( instr_rvalid_o  ),
    .sdata_rvalid_i  ( sdata_rvalid_o  ),
    .vdata_rvalid_i  ( vdata_rvalid_o  )
);

/* test/vproc_mem_fabric_tb.sv */
// testbench for the vector coprocessor memory fabric
// table-driven fetch, scalar and vector accesses against an in-order memory model

module vproc_mem_fabric_tb;

    typedef struct {
        string       name;
        int          port;     // 0 fetch, 1 scalar, 2 vector, 3 scalar plus fetch
        logic        we;
        logic [31:0] addr;
        logic [63:0] data;
        logic [7:0]  be;
        logic        pl;
        logic        ps;
        logic [63:0] exp;
        logic [63:0] exp2;     // fetch result of a port 3 row
    } row_t;

    logic clk_i, rst_ni;
    logic instr_req_i, instr_gnt_o, instr_rvalid_o, instr_err_o;
    logic [31:0] instr_addr_i, instr_rdata_o;
    logic sdata_req_i, sdata_we_i, sdata_gnt_o, sdata_rvalid_o, sdata_err_o;
    logic [31:0] sdata_addr_i, sdata_wdata_i, sdata_rdata_o;
    logic [3:0]  sdata_be_i;
    logic vdata_req_i, vdata_we_i, vdata_gnt_o, vdata_rvalid_o, vdata_err_o;
    logic [31:0] vdata_addr_i;
    logic [7:0]  vdata_be_i;
    vproc_mem_pkg::mem_word_u vdata_wdata_i, vdata_rdata_o;
    logic pending_load_i, pending_store_i;
    logic mem_req_o, mem_we_o, mem_rvalid_i, mem_err_i;
    logic [31:0] mem_addr_o;
    logic [7:0]  mem_be_o;
    vproc_mem_pkg::mem_word_u mem_wdata_o, mem_rdata_i;

    row_t        rows[$];
    logic [63:0] mem[logic [31:0]];
    logic [63:0] shadow[logic [31:0]];
    logic [63:0] resp_data[$];
    logic        resp_err[$];
    longint      resp_due[$];
    longint      cyc = 0, last_due = 0;
    logic [31:0] seed = 32'hb5bf2435;
    int          errors = 0, checks = 0;
    logic        rows_ready = 1'b0;

    vproc_mem_fabric i_dut (.*);

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    function automatic logic [31:0] lcg();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // unwritten words depend on the full word address
    function automatic logic [63:0] fill(input logic [31:0] a);
        logic [31:0] w;
        w = {a[31:3], 3'b000};
        return {w ^ 32'h5a5aa5a5, ~w};
    endfunction

    // the 4 KiB block at 0xe000 answers with a bus error
    function automatic logic is_err_addr(input logic [31:0] a);
        return a[31:12] == 20'h0000e;
    endfunction

    function automatic logic [63:0] merge(input logic [63:0] old, input logic [63:0] d,
                                          input logic [7:0] be);
        logic [63:0] r;
        r = old;
        for (int b = 0; b < 8; b++) begin
            if (be[b]) r[b*8 +: 8] = d[b*8 +: 8];
        end
        return r;
    endfunction

    function automatic logic [63:0] shadow_word(input logic [31:0] a);
        logic [31:0] k;
        k = {a[31:3], 3'b000};
        return shadow.exists(k) ? shadow[k] : fill(k);
    endfunction

    ////////////////////////////////////////////////////////////
    // memory model, in order, 1 to 4 cycles latency

    always @(posedge clk_i) begin
        logic [31:0] k;
        logic [63:0] w;
        longint      due;
        cyc = cyc + 1;
        mem_rvalid_i <= 1'b0;
        mem_err_i    <= 1'b0;
        if (resp_due.size() > 0 && resp_due[0] <= cyc) begin
            mem_rvalid_i    <= 1'b1;
            mem_rdata_i.raw <= resp_data.pop_front();
            mem_err_i       <= resp_err.pop_front();
            void'(resp_due.pop_front());
        end
        if (rst_ni && mem_req_o) begin
            k = {mem_addr_o[31:3], 3'b000};
            w = mem.exists(k) ? mem[k] : fill(k);
            if (mem_we_o) mem[k] = merge(w, mem_wdata_o.raw, mem_be_o);
            due = cyc + 1 + longint'((lcg() >> 16) % 4);
            if (due <= last_due) due = last_due + 1;   // one response per cycle
            last_due = due;
            resp_data.push_back(w);
            resp_err.push_back(is_err_addr(k));
            resp_due.push_back(due);
        end
    end

    ////////////////////////////////////////////////////////////
    // table construction, expected values from the shadow memory

    task automatic add(input string name, input int port, input logic we,
                       input logic [31:0] addr, input logic [63:0] data,
                       input logic [7:0] be, input logic pl, input logic ps);
        row_t        r;
        logic [63:0] w;
        logic [7:0]  be64;
        r = '{name, port, we, addr, data, be, pl, ps, 64'h0, 64'h0};
        w = shadow_word(addr);
        if (port == 2) begin
            if (we) shadow[{addr[31:3], 3'b000}] = merge(w, data, be);
            else r.exp = w;
        end else begin
            be64 = addr[2] ? {be[3:0], 4'b0000} : {4'b0000, be[3:0]};
            if (we) shadow[{addr[31:3], 3'b000}] = merge(w, {data[31:0], data[31:0]}, be64);
            else r.exp = {32'h0, addr[2] ? w[63:32] : w[31:0]};
        end
        if (port == 3) begin
            w = shadow_word(addr ^ 32'h4);   // data is served before the fetch
            r.exp2 = {32'h0, addr[2] ? w[31:0] : w[63:32]};
        end
        rows.push_back(r);
    endtask

    function automatic logic gnt_of(input int port);
        return port == 0 ? instr_gnt_o : (port == 1 ? sdata_gnt_o : vdata_gnt_o);
    endfunction

    function automatic logic rvalid_of(input int port);
        return port == 0 ? instr_rvalid_o : (port == 1 ? sdata_rvalid_o : vdata_rvalid_o);
    endfunction

    function automatic logic err_of(input int port);
        return port == 0 ? instr_err_o : (port == 1 ? sdata_err_o : vdata_err_o);
    endfunction

    function automatic logic [63:0] rdata_of(input int port);
        if (port == 0) return {32'h0, instr_rdata_o};
        if (port == 1) return {32'h0, sdata_rdata_o};
        return vdata_rdata_o.raw;
    endfunction

    task automatic access(input int port, input logic we, input logic [31:0] addr,
                          input logic [63:0] data, input logic [7:0] be, input logic held,
                          input logic [63:0] exp, input string name, output longint gnt_t);
        logic [63:0] act;
        logic        act_err;
        @(posedge clk_i);
        case (port)
            0: begin
                instr_req_i  <= 1'b1;
                instr_addr_i <= addr;
            end
            1: begin
                sdata_req_i   <= 1'b1;
                sdata_addr_i  <= addr;
                sdata_we_i    <= we;
                sdata_be_i    <= be[3:0];
                sdata_wdata_i <= data[31:0];
            end
            default: begin
                vdata_req_i       <= 1'b1;
                vdata_addr_i      <= addr;
                vdata_we_i        <= we;
                vdata_be_i        <= be;
                vdata_wdata_i.raw <= data;
            end
        endcase
        if (held) begin
            repeat (3) begin
                @(negedge clk_i);
                assert (!sdata_gnt_o) else begin
                    errors++;
                    $display("scalar request %s was granted while pending flags were set", name);
                end
            end
            @(posedge clk_i);
            pending_load_i  <= 1'b0;
            pending_store_i <= 1'b0;
        end
        do @(negedge clk_i); while (!gnt_of(port));
        gnt_t = cyc;
        @(posedge clk_i);
        if (port == 0) instr_req_i <= 1'b0;
        else if (port == 1) sdata_req_i <= 1'b0;
        else vdata_req_i <= 1'b0;
        do @(negedge clk_i); while (!rvalid_of(port));   // writes answer too
        act     = rdata_of(port);
        act_err = err_of(port);
        checks++;
        assert (we || act == exp) else begin
            errors++;
            $display("ERR %s: expected %h, actual %h", name, exp, act);
        end
        checks++;
        assert (act_err == is_err_addr(addr)) else begin
            errors++;
            $display("ERR %s_err: expected %b, actual %b", name, is_err_addr(addr), act_err);
        end
    endtask

    task automatic run_row(input row_t r);
        longint sg, ig;
        @(posedge clk_i);
        pending_load_i  <= r.pl;
        pending_store_i <= r.ps;
        if (r.port == 3) begin
            fork
                access(1, r.we, r.addr, r.data, r.be, 1'b0, r.exp, r.name, sg);
                access(0, 1'b0, r.addr ^ 32'h4, 64'h0, 8'h0, 1'b0, r.exp2,
                       {r.name, "_fetch"}, ig);
            join
            assert (sg < ig) else begin
                errors++;
                $display("fetch in %s was granted before the data request", r.name);
            end
        end else begin
            access(r.port, r.we, r.addr, r.data, r.be,
                   r.port == 1 && (r.ps || (r.pl && r.we)), r.exp, r.name, sg);
        end
        @(posedge clk_i);
        pending_load_i  <= 1'b0;
        pending_store_i <= 1'b0;
    endtask

    initial begin
        logic [31:0] r, a;
        int          p;
        {instr_req_i, sdata_req_i, sdata_we_i, vdata_req_i, vdata_we_i} = '0;
        {instr_addr_i, sdata_addr_i, sdata_wdata_i, vdata_addr_i} = '0;
        {sdata_be_i, vdata_be_i, vdata_wdata_i} = '0;
        {pending_load_i, pending_store_i, mem_rvalid_i, mem_err_i} = '0;
        mem_rdata_i = '0;
        rst_ni = 1'b0;

        add("fetch_lo", 0, 0, 32'h200, 0, 0, 0, 0);
        add("fetch_hi", 0, 0, 32'h204, 0, 0, 0, 0);
        add("vec_write", 2, 1, 32'h300, 64'h0123456789abcdef, 8'hff, 0, 0);
        add("vec_read", 2, 0, 32'h300, 0, 0, 0, 0);
        add("vec_write_be", 2, 1, 32'h300, 64'hfedcba9876543210, 8'h3c, 0, 0);
        add("vec_read_be", 2, 0, 32'h300, 0, 0, 0, 0);
        add("scalar_write_hi", 1, 1, 32'h304, 32'hdeadbeef, 8'h06, 0, 0);
        add("scalar_read_hi", 1, 0, 32'h304, 0, 0, 0, 0);
        add("vec_read_both", 2, 0, 32'h300, 0, 0, 0, 0);
        add("store_hold_write", 1, 1, 32'h308, 32'h11223344, 8'h0f, 0, 1);
        add("store_hold_read", 1, 0, 32'h308, 0, 0, 0, 1);
        add("load_hold_write", 1, 1, 32'h30c, 32'h55667788, 8'h0f, 1, 0);
        add("load_pass_read", 1, 0, 32'h30c, 0, 0, 1, 0);
        add("prio_write", 3, 1, 32'h400, 32'hcafef00d, 8'h0f, 0, 0);
        add("prio_read", 3, 0, 32'h404, 0, 0, 0, 0);
        add("fetch_err", 0, 0, 32'he004, 0, 0, 0, 0);
        add("scalar_err", 1, 0, 32'he000, 0, 0, 0, 0);
        add("vec_err", 2, 0, 32'he008, 0, 0, 0, 0);
        for (int i = 0; i < 24; i++) begin
            r = lcg();
            p = int'((r >> 8) % 3);
            a = lcg();
            a = 32'h1000 | (a & (p == 2 ? 32'h38 : 32'h3c));
            add($sformatf("rand_%0d", i), p, p != 0 && r[20], a, {lcg(), lcg()},
                p == 2 ? r[7:0] : {4'b0000, r[3:0]}, 0, 0);
        end
        rows_ready = 1'b1;

        repeat (3) @(posedge clk_i);
        rst_ni <= 1'b1;
        foreach (rows[i]) run_row(rows[i]);
        repeat (4) @(posedge clk_i);

        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    // budget of 40 cycles per row
    initial begin
        wait (rows_ready);
        #(longint'(rows.size()) * 40 * 40);
        $display("timeout: the DUT did not finish all table rows in time");
        $display("sim failed");
        $finish;
    end

endmodule

/* vproc_mem_fabric.f */
hw/vproc_mem_pkg.sv
hw/ls_data_arbiter.sv
hw/resp_order_queue.sv
hw/mem_port_arbiter.sv
hw/vproc_mem_fabric.sv
test/vproc_mem_fabric_assertions.sv
test/vproc_mem_fabric_tb.sv

/* Makefile */
SIM_BIN = obj_dir/Vvproc_mem_fabric_tb

.PHONY: compile run clean

compile:
	verilator --binary --assert -Wno-fatal --top-module vproc_mem_fabric_tb \
		-f vproc_mem_fabric.f -Mdir obj_dir

run: compile
	./$(SIM_BIN) > sim.log 2>&1 || true
	cat sim.log
	! grep -q "sim failed" sim.log
	grep -q "sim passed" sim.log

clean:
	rm -rf obj_dir sim.log
